//--- include/sdio_dat_defines.svh
`ifndef SDIO_DAT_DEFINES_SVH
`define SDIO_DAT_DEFINES_SVH

`define SDIO_CRC_LEN    16
`define SDIO_CRC_POLY   16'h1021  // x16 + x12 + x5 + 1
`define SDIO_SIZE_W     16
`define SDIO_NWR_BITS   2         // high bits ahead of a write start bit
`define SDIO_LANES      4

`endif

//--- design/sdio_line_pkg.sv
`include "sdio_dat_defines.svh"

package sdio_line_pkg;

    // one bit per DAT line
    typedef logic [`SDIO_LANES-1:0] lane_t;

    typedef logic [7:0] data_byte_t;

    typedef logic [`SDIO_CRC_LEN-1:0] crc16_t;

    // lane 0 in the low slot
    typedef crc16_t [`SDIO_LANES-1:0] crc_bank_t;

    typedef logic [`SDIO_SIZE_W-1:0] size_t;  // block size or block count

endpackage

//--- design/sdio_seq_pkg.sv
package sdio_seq_pkg;

    typedef enum logic [1:0] {
        IDLE,
        RUN_BLOCK,
        BLK_GAP
    } ctrl_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_DMA_WR,
        RX_CRC,
        RX_END
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PRE,
        TX_START,
        TX_DMA_RD,
        TX_DATA,
        TX_CRC,
        TX_END,
        TX_RELEASE
    } tx_state_t;

endpackage

//--- design/sdio_dat_ifs.sv
`timescale 1ns/10ps

// one engine's view of the shared crc bank
interface crc_lane_if
    import sdio_line_pkg::*;
();
    logic      clr;    // pulse on the start bit
    logic      shift;  // pulse per lane bit
    logic      wide;
    lane_t     din;
    crc_bank_t crc;

    modport requester (
        output clr,
        output shift,
        output din,
        output wide,
        input  crc
    );

    modport bank (
        input  clr,
        input  shift,
        input  din,
        input  wide,
        output crc
    );
endinterface

// block launch and completion between controller and one engine
interface blk_seq_if;
    logic blk_start;
    logic blk_end;
    logic crc_err;  // valid with blk_end
    logic end_err;

    modport ctrl (output blk_start, input blk_end, input crc_err, input end_err);
    modport engine (input blk_start, output blk_end, output crc_err, output end_err);
endinterface

//--- design/crc16_bank.sv
`timescale 1ns/10ps
`include "sdio_dat_defines.svh"

module crc16_bank
    import sdio_line_pkg::*;
(
    input  logic     sd_clk,
    input  logic     rstn,
    crc_lane_if.bank rx_req,
    crc_lane_if.bank tx_req
);

    crc_bank_t crc_q;
    logic      clr;
    logic      shift;
    logic      wide;
    lane_t     din;

    // one msb-first step of the data crc
    function automatic crc16_t crc_step(crc16_t c, logic b);
        crc16_t nxt;
        nxt = {c[`SDIO_CRC_LEN-2:0], 1'b0};
        if (c[`SDIO_CRC_LEN-1] ^ b)
            nxt = nxt ^ `SDIO_CRC_POLY;
        return nxt;
    endfunction

    // engines never overlap, the strobing one owns the bank
    assign clr   = rx_req.clr | tx_req.clr;
    assign shift = rx_req.shift | tx_req.shift;
    assign din   = rx_req.shift ? rx_req.din : tx_req.din;
    assign wide  = rx_req.shift ? rx_req.wide : tx_req.wide;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            crc_q <= '0;
        end else if (clr) begin
            crc_q <= '0;  // clear wins over shift
        end else if (shift) begin
            for (int i = 0; i < `SDIO_LANES; i++) begin
                if (i == 0 || wide)
                    crc_q[i] <= crc_step(crc_q[i], din[i]);
            end
        end
    end

    assign rx_req.crc = crc_q;
    assign tx_req.crc = crc_q;

endmodule

//--- design/dat_rx_engine.sv
`timescale 1ns/10ps
`include "sdio_dat_defines.svh"

module dat_rx_engine
    import sdio_line_pkg::*, sdio_seq_pkg::*;
(
    input  logic          sd_clk,
    input  logic          rstn,
    input  logic          rx_en_i,
    input  logic          wide_i,
    input  size_t         block_size_i,
    input  lane_t         dat_i,
    blk_seq_if.engine     seq,
    crc_lane_if.requester crc,
    input  logic          dma_rx_buf_rdy_i,
    output data_byte_t    dma_rx_buf_o,
    output logic          dma_rx_buf_wr_o
);

    rx_state_t  state_q;
    rx_state_t  state_d;
    logic [2:0] bit_cnt_q;
    logic [3:0] crc_cnt_q;
    size_t      byte_cnt_q;
    logic       crc_err_q;
    logic       start_bit;
    logic       end_bit;
    logic       last_bit;
    logic       last_byte;
    logic       crc_miss;
    lane_t      crc_bits;

    assign start_bit = wide_i ? (dat_i == '0) : !dat_i[0];
    assign end_bit   = wide_i ? (dat_i == '1) : dat_i[0];
    assign last_bit  = bit_cnt_q == (wide_i ? 3'd1 : 3'd7);  // two nibbles or eight bits
    assign last_byte = byte_cnt_q == block_size_i;

    // expected crc bit on each lane
    always_comb begin
        for (int i = 0; i < `SDIO_LANES; i++)
            crc_bits[i] = crc.crc[i][`SDIO_CRC_LEN - 1 - crc_cnt_q];
    end

    assign crc_miss = wide_i ? (crc_bits != dat_i) : (crc_bits[0] != dat_i[0]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_IDLE:   if (seq.blk_start) state_d = RX_START;
            RX_START:  if (rx_en_i && start_bit) state_d = RX_DATA;
            RX_DATA:   if (rx_en_i && last_bit) state_d = RX_DMA_WR;
            RX_DMA_WR: if (dma_rx_buf_rdy_i) state_d = last_byte ? RX_CRC : RX_DATA;
            RX_CRC:    if (rx_en_i && crc_cnt_q == 4'(`SDIO_CRC_LEN - 1)) state_d = RX_END;
            RX_END:    if (rx_en_i) state_d = RX_IDLE;
            default:   state_d = RX_IDLE;
        endcase
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            state_q    <= RX_IDLE;
            bit_cnt_q  <= '0;
            crc_cnt_q  <= '0;
            byte_cnt_q <= '0;
            crc_err_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            case (state_q)
                RX_START: if (rx_en_i && start_bit) begin
                    bit_cnt_q  <= '0;
                    crc_cnt_q  <= '0;
                    byte_cnt_q <= '0;
                    crc_err_q  <= 1'b0;
                end
                RX_DATA: if (rx_en_i) begin
                    if (last_bit) begin
                        bit_cnt_q  <= '0;
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                RX_CRC: if (rx_en_i) begin
                    crc_cnt_q <= crc_cnt_q + 1'b1;
                    if (crc_miss)
                        crc_err_q <= 1'b1;  // sticky until next start bit
                end
                default: ;
            endcase
        end
    end

    // byte assembly, msb first
    always_ff @(posedge sd_clk) begin
        if (state_q == RX_DATA && rx_en_i) begin
            if (!wide_i)
                dma_rx_buf_o[3'd7 - bit_cnt_q] <= dat_i[0];
            else if (bit_cnt_q == 3'd0)
                dma_rx_buf_o[7:4] <= dat_i;
            else
                dma_rx_buf_o[3:0] <= dat_i;
        end
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn)
            dma_rx_buf_wr_o <= 1'b0;
        else
            dma_rx_buf_wr_o <= (state_q == RX_DMA_WR) && dma_rx_buf_rdy_i;
    end

    assign crc.clr   = (state_q == RX_START) && rx_en_i && start_bit;
    assign crc.shift = (state_q == RX_DATA) && rx_en_i;
    assign crc.din   = dat_i;
    assign crc.wide  = wide_i;

    assign seq.blk_end = (state_q == RX_END) && rx_en_i;  // end bit strobe
    assign seq.crc_err = crc_err_q;
    assign seq.end_err = !end_bit;

endmodule

//--- design/dat_tx_engine.sv
`timescale 1ns/10ps
`include "sdio_dat_defines.svh"

module dat_tx_engine
    import sdio_line_pkg::*, sdio_seq_pkg::*;
(
    input  logic          sd_clk,
    input  logic          rstn,
    input  logic          tx_en_i,
    input  logic          wide_i,
    input  size_t         block_size_i,
    blk_seq_if.engine     seq,
    crc_lane_if.requester crc,
    input  logic          dma_tx_byte_rdy_i,
    input  data_byte_t    dma_tx_byte_i,
    output logic          dma_tx_byte_end_o,
    output lane_t         dat_o,
    output lane_t         dat_oe_o
);

    tx_state_t  state_q;
    tx_state_t  state_d;
    logic [1:0] pre_cnt_q;
    logic [2:0] bit_cnt_q;
    logic [3:0] crc_cnt_q;
    size_t      byte_cnt_q;
    logic       byte_vld_q;
    data_byte_t byte_q;
    logic       last_bit;
    logic       last_byte;
    lane_t      active;
    lane_t      tx_bits;
    lane_t      crc_bits;

    assign active    = wide_i ? '1 : lane_t'(1);  // lanes driven in this mode
    assign last_bit  = bit_cnt_q == (wide_i ? 3'd1 : 3'd7);
    assign last_byte = byte_cnt_q == block_size_i;

    // high nibble first in 4-bit mode, idle lanes stay high in 1-bit mode
    always_comb begin
        if (wide_i)
            tx_bits = bit_cnt_q[0] ? byte_q[3:0] : byte_q[7:4];
        else
            tx_bits = {3'b111, byte_q[3'd7 - bit_cnt_q]};
    end

    always_comb begin
        for (int i = 0; i < `SDIO_LANES; i++)
            crc_bits[i] = crc.crc[i][`SDIO_CRC_LEN - 1 - crc_cnt_q];
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TX_IDLE:    if (seq.blk_start) state_d = TX_PRE;
            TX_PRE:     if (tx_en_i && pre_cnt_q == 2'(`SDIO_NWR_BITS - 1)) state_d = TX_START;
            TX_START:   if (tx_en_i) state_d = TX_DMA_RD;
            TX_DMA_RD:  if (byte_vld_q) state_d = TX_DATA;
            TX_DATA:    if (tx_en_i && last_bit) state_d = last_byte ? TX_CRC : TX_DMA_RD;
            TX_CRC:     if (tx_en_i && crc_cnt_q == 4'(`SDIO_CRC_LEN - 1)) state_d = TX_END;
            TX_END:     if (tx_en_i) state_d = TX_RELEASE;
            TX_RELEASE: if (tx_en_i) state_d = TX_IDLE;
            default:    state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            state_q    <= TX_IDLE;
            pre_cnt_q  <= '0;
            bit_cnt_q  <= '0;
            crc_cnt_q  <= '0;
            byte_cnt_q <= '0;
            dat_o      <= '1;
            dat_oe_o   <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                TX_IDLE: pre_cnt_q <= '0;
                TX_PRE: if (tx_en_i) begin
                    dat_o     <= '1;
                    dat_oe_o  <= active;
                    pre_cnt_q <= pre_cnt_q + 1'b1;
                end
                TX_START: if (tx_en_i) begin
                    dat_o      <= ~active;  // start bit on active lanes only
                    bit_cnt_q  <= '0;
                    byte_cnt_q <= '0;
                end
                TX_DMA_RD: if (byte_vld_q) byte_cnt_q <= byte_cnt_q + 1'b1;
                TX_DATA: if (tx_en_i) begin
                    dat_o     <= tx_bits;
                    crc_cnt_q <= '0;
                    bit_cnt_q <= last_bit ? 3'd0 : bit_cnt_q + 1'b1;
                end
                TX_CRC: if (tx_en_i) begin
                    dat_o     <= crc_bits | ~active;
                    crc_cnt_q <= crc_cnt_q + 1'b1;
                end
                TX_END: if (tx_en_i) dat_o <= '1;
                TX_RELEASE: if (tx_en_i) dat_oe_o <= '0;
                default: ;
            endcase
        end
    end

    // ready is a single pulse, hold it until the byte is sent
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn)
            byte_vld_q <= 1'b0;
        else if (dma_tx_byte_rdy_i)
            byte_vld_q <= 1'b1;
        else if (dma_tx_byte_end_o)
            byte_vld_q <= 1'b0;
    end

    always_ff @(posedge sd_clk) begin
        if (dma_tx_byte_rdy_i)
            byte_q <= dma_tx_byte_i;
    end

    assign dma_tx_byte_end_o = (state_q == TX_DATA) && tx_en_i && last_bit;

    assign crc.clr   = (state_q == TX_START) && tx_en_i;
    assign crc.shift = (state_q == TX_DATA) && tx_en_i;
    assign crc.din   = tx_bits;
    assign crc.wide  = wide_i;

    assign seq.blk_end = (state_q == TX_RELEASE) && tx_en_i;
    assign seq.crc_err = 1'b0;  // no crc status token on writes
    assign seq.end_err = 1'b0;

endmodule

//--- design/dat_ctrl.sv
`timescale 1ns/10ps

module dat_ctrl
    import sdio_line_pkg::*, sdio_seq_pkg::*;
(
    input  logic      sd_clk,
    input  logic      rstn,
    input  logic      dat_start_i,
    input  logic      dir_i,           // 1 read, 0 write
    input  size_t     block_count_i,   // 0 runs forever
    input  logic      blk_gap_stop_i,
    blk_seq_if.ctrl   rx_seq,
    blk_seq_if.ctrl   tx_seq,
    output logic      crc_err_event_o,
    output logic      end_err_event_o,
    output logic      blk_gap_event_o,
    output logic      busy_o,
    output logic      done_o
);

    ctrl_state_t state_q;
    logic        dir_q;
    logic        launched_q;  // blk_start already issued for this block
    logic        blk_start_q;
    size_t       blk_cnt_q;
    size_t       blk_next;
    logic        blk_end;
    logic        last_blk;

    assign blk_end  = (state_q == RUN_BLOCK) && (dir_q ? rx_seq.blk_end : tx_seq.blk_end);
    assign blk_next = blk_cnt_q + 1'b1;
    assign last_blk = (block_count_i != '0) && (blk_next == block_count_i);

    assign rx_seq.blk_start = blk_start_q & dir_q;
    assign tx_seq.blk_start = blk_start_q & ~dir_q;
    assign busy_o           = state_q != IDLE;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            state_q         <= IDLE;
            dir_q           <= 1'b0;
            launched_q      <= 1'b0;
            blk_start_q     <= 1'b0;
            blk_cnt_q       <= '0;
            crc_err_event_o <= 1'b0;
            end_err_event_o <= 1'b0;
            blk_gap_event_o <= 1'b0;
            done_o          <= 1'b0;
        end else begin
            blk_start_q     <= 1'b0;
            crc_err_event_o <= blk_end && (dir_q ? rx_seq.crc_err : tx_seq.crc_err);
            end_err_event_o <= blk_end && (dir_q ? rx_seq.end_err : tx_seq.end_err);
            blk_gap_event_o <= blk_end && !last_blk;
            done_o          <= blk_end && last_blk;
            case (state_q)
                IDLE: if (dat_start_i) begin
                    state_q    <= RUN_BLOCK;
                    dir_q      <= dir_i;
                    blk_cnt_q  <= '0;
                    launched_q <= 1'b0;
                end
                RUN_BLOCK: begin
                    if (!launched_q) begin
                        blk_start_q <= 1'b1;
                        launched_q  <= 1'b1;
                    end
                    if (blk_end) begin
                        blk_cnt_q <= blk_next;
                        state_q   <= last_blk ? IDLE : BLK_GAP;
                    end
                end
                BLK_GAP: if (!blk_gap_stop_i) begin  // hold while stop is set
                    state_q    <= RUN_BLOCK;
                    launched_q <= 1'b0;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

//--- design/sdio_dat_top.sv
`timescale 1ns/10ps

module sdio_dat_top
    import sdio_line_pkg::*;
(
    input  logic       sd_clk,
    input  logic       rstn,
    input  logic       dat_start_i,
    input  logic       dir_i,          // 1 read, 0 write
    input  logic       wide_i,         // 1 for 4-bit bus
    input  size_t      block_size_i,
    input  size_t      block_count_i,
    input  logic       blk_gap_stop_i,
    input  logic       rx_en_i,
    input  logic       tx_en_i,
    output logic       crc_err_event_o,
    output logic       end_err_event_o,
    output logic       blk_gap_event_o,
    output logic       busy_o,
    output logic       done_o,
    input  logic       dma_rx_buf_rdy_i,
    output data_byte_t dma_rx_buf_o,
    output logic       dma_rx_buf_wr_o,
    input  logic       dma_tx_byte_rdy_i,
    input  data_byte_t dma_tx_byte_i,
    output logic       dma_tx_byte_end_o,
    input  lane_t      dat_i,
    output lane_t      dat_o,
    output lane_t      dat_oe_o
);

    blk_seq_if  rx_seq ();
    blk_seq_if  tx_seq ();
    crc_lane_if rx_crc ();
    crc_lane_if tx_crc ();

    crc16_bank i_crc_bank (
        .sd_clk (sd_clk),
        .rstn   (rstn),
        .rx_req (rx_crc.bank),
        .tx_req (tx_crc.bank)
    );

    dat_rx_engine i_rx (
        .sd_clk           (sd_clk),
        .rstn             (rstn),
        .rx_en_i          (rx_en_i),
        .wide_i           (wide_i),
        .block_size_i     (block_size_i),
        .dat_i            (dat_i),
        .seq              (rx_seq.engine),
        .crc              (rx_crc.requester),
        .dma_rx_buf_rdy_i (dma_rx_buf_rdy_i),
        .dma_rx_buf_o     (dma_rx_buf_o),
        .dma_rx_buf_wr_o  (dma_rx_buf_wr_o)
    );

    dat_tx_engine i_tx (
        .sd_clk            (sd_clk),
        .rstn              (rstn),
        .tx_en_i           (tx_en_i),
        .wide_i            (wide_i),
        .block_size_i      (block_size_i),
        .seq               (tx_seq.engine),
        .crc               (tx_crc.requester),
        .dma_tx_byte_rdy_i (dma_tx_byte_rdy_i),
        .dma_tx_byte_i     (dma_tx_byte_i),
        .dma_tx_byte_end_o (dma_tx_byte_end_o),
        .dat_o             (dat_o),
        .dat_oe_o          (dat_oe_o)
    );

    dat_ctrl i_ctrl (
        .sd_clk          (sd_clk),
        .rstn            (rstn),
        .dat_start_i     (dat_start_i),
        .dir_i           (dir_i),
        .block_count_i   (block_count_i),
        .blk_gap_stop_i  (blk_gap_stop_i),
        .rx_seq          (rx_seq.ctrl),
        .tx_seq          (tx_seq.ctrl),
        .crc_err_event_o (crc_err_event_o),
        .end_err_event_o (end_err_event_o),
        .blk_gap_event_o (blk_gap_event_o),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

endmodule

//--- bench/sdio_dat_properties.sv
`timescale 1ns/10ps
`include "sdio_dat_defines.svh"

module sdio_dat_properties (
    input logic                   sd_clk,
    input logic                   rstn,
    input logic                   busy_o,
    input logic                   done_o,
    input logic                   dma_rx_buf_rdy_i,
    input logic                   dma_rx_buf_wr_o,
    input logic [`SDIO_LANES-1:0] dat_oe_o
);

    // buffer write is a single cycle pulse
    wr_single: assert property (@(posedge sd_clk) disable iff (!rstn)
        dma_rx_buf_wr_o |=> !dma_rx_buf_wr_o)
        else $error("dma_rx_buf_wr_o held longer than one cycle");

    wr_after_rdy: assert property (@(posedge sd_clk) disable iff (!rstn)
        dma_rx_buf_wr_o |-> $past(dma_rx_buf_rdy_i))
        else $error("dma_rx_buf_wr_o without a preceding ready");

    done_drops_busy: assert property (@(posedge sd_clk) disable iff (!rstn)
        done_o |=> !busy_o)
        else $error("busy_o still high after done_o");

    // lines only driven inside a transfer
    oe_idle: assert property (@(posedge sd_clk) disable iff (!rstn)
        !busy_o |-> (dat_oe_o == '0))
        else $error("dat_oe_o active while not busy");

    busy_in_reset: assert property (@(posedge sd_clk)
        !rstn |-> !busy_o)
        else $error("busy_o high during reset");

endmodule

bind sdio_dat_top sdio_dat_properties i_props (
    .sd_clk           (sd_clk),
    .rstn             (rstn),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .dma_rx_buf_rdy_i (dma_rx_buf_rdy_i),
    .dma_rx_buf_wr_o  (dma_rx_buf_wr_o),
    .dat_oe_o         (dat_oe_o)
);

//--- bench/tb_sdio_dat.sv
`timescale 1ns/10ps
`include "sdio_dat_defines.svh"

module tb_sdio_dat
    import sdio_line_pkg::*;
();

    localparam int BYTES_TOTAL    = 34;   // sum over all blocks below
    localparam int BLOCKS_TOTAL   = 9;
    localparam int CYCLES_PER_BIT = 8;    // strobe, idle gap and dma wait
    localparam int BLOCK_SLACK    = 300;  // framing, crc and gap hold
    localparam int WATCHDOG_CYCLES = BYTES_TOTAL * 8 * CYCLES_PER_BIT
                                   + BLOCKS_TOTAL * BLOCK_SLACK;

    logic       sd_clk;
    logic       rstn;
    logic       dat_start;
    logic       dir;
    logic       wide;
    size_t      bsize;
    size_t      bcount;
    logic       gap_stop;
    logic       rx_en;
    logic       tx_en;
    logic       rx_rdy;
    logic       tx_rdy;
    data_byte_t tx_byte;
    lane_t      dat_in;
    logic       crc_err_event;
    logic       end_err_event;
    logic       blk_gap_event;
    logic       busy;
    logic       done;
    data_byte_t rx_buf;
    logic       rx_buf_wr;
    logic       tx_byte_end;
    lane_t      dat_out;
    lane_t      dat_oe;

    int         err_cnt;
    int         chk_cnt;
    int         gap_cnt;
    int         done_cnt;
    int         crc_ev_cnt;
    int         end_ev_cnt;
    data_byte_t rx_exp[$];  // bytes the card has sent in order

    sdio_dat_top i_dut (
        .sd_clk (sd_clk), .rstn (rstn), .dat_start_i (dat_start), .dir_i (dir),
        .wide_i (wide), .block_size_i (bsize), .block_count_i (bcount),
        .blk_gap_stop_i (gap_stop), .rx_en_i (rx_en), .tx_en_i (tx_en),
        .crc_err_event_o (crc_err_event), .end_err_event_o (end_err_event),
        .blk_gap_event_o (blk_gap_event), .busy_o (busy), .done_o (done),
        .dma_rx_buf_rdy_i (rx_rdy), .dma_rx_buf_o (rx_buf), .dma_rx_buf_wr_o (rx_buf_wr),
        .dma_tx_byte_rdy_i (tx_rdy), .dma_tx_byte_i (tx_byte),
        .dma_tx_byte_end_o (tx_byte_end), .dat_i (dat_in), .dat_o (dat_out),
        .dat_oe_o (dat_oe)
    );

    initial begin
        sd_clk = 1'b0;
        forever #10 sd_clk = ~sd_clk;
    end

    // reference crc16 step for x16+x12+x5+1 msb first
    function automatic crc16_t crc_next(crc16_t c, logic b);
        return {c[14:0], 1'b0} ^ ((c[15] ^ b) ? 16'h1021 : 16'h0000);
    endfunction

    task automatic expect_value(input int act, input int exp, input string what);
        chk_cnt++;
        assert (act == exp) else begin
            err_cnt++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, act, exp);
        end
    endtask

    // dma side of reads with random ready
    always @(posedge sd_clk) rx_rdy <= ($urandom % 4) == 0;

    always @(negedge sd_clk) begin
        if (rstn) begin
            if (blk_gap_event) gap_cnt++;
            if (done) done_cnt++;
            if (crc_err_event) crc_ev_cnt++;
            if (end_err_event) end_ev_cnt++;
            if (rx_buf_wr) begin
                if (rx_exp.size() == 0) begin
                    err_cnt++;
                    $display("unexpected DMA buffer write at %0t", $time);
                end else begin
                    expect_value(rx_buf, rx_exp.pop_front(), "read byte");
                end
            end
        end
    end

    task automatic start_transfer(input logic rd, input logic w, input int sz, input int cnt);
        @(posedge sd_clk);
        dir       <= rd;
        wide      <= w;
        bsize     <= size_t'(sz);
        bcount    <= size_t'(cnt);
        dat_start <= 1'b1;
        @(posedge sd_clk);
        dat_start <= 1'b0;
        repeat (3) @(posedge sd_clk);  // blk_start reaches the engine
    endtask

    // one card bit on the bus with its strobe
    task automatic rx_strobe(input lane_t bits);
        repeat ($urandom % 3) @(posedge sd_clk);
        @(posedge sd_clk);
        rx_en  <= 1'b1;
        dat_in <= bits;
        @(posedge sd_clk);
        rx_en  <= 1'b0;
        @(negedge sd_clk);
    endtask

    task automatic read_block(input int nbytes, input logic flip_crc, input logic bad_end);
        crc_bank_t  ref_crc;
        data_byte_t b;
        lane_t      bits;
        int         nbits;
        ref_crc = '0;
        nbits = wide ? 2 : 8;
        rx_strobe(4'b1111);
        rx_strobe(wide ? 4'b0000 : 4'b1110);  // start bit
        for (int i = 0; i < nbytes; i++) begin
            b = data_byte_t'($urandom);
            rx_exp.push_back(b);
            for (int k = 0; k < nbits; k++) begin
                bits = wide ? ((k == 0) ? b[7:4] : b[3:0]) : {3'b111, b[7-k]};
                for (int l = 0; l < 4; l++)
                    if (wide || l == 0) ref_crc[l] = crc_next(ref_crc[l], bits[l]);
                rx_strobe(bits);
            end
            do @(negedge sd_clk); while (!rx_buf_wr);  // card waits out dma stall
        end
        if (flip_crc)
            ref_crc[0][5] = ~ref_crc[0][5];
        for (int k = 15; k >= 0; k--) begin
            for (int l = 0; l < 4; l++)
                bits[l] = (wide || l == 0) ? ref_crc[l][k] : 1'b1;
            rx_strobe(bits);
        end
        rx_strobe(bad_end ? 4'b1110 : 4'b1111);
        expect_value(crc_err_event, flip_crc, "crc error event");
        expect_value(end_err_event, bad_end, "end bit error event");
    endtask

    // strobe, then check the lines one cycle later
    task automatic tx_strobe(input lane_t exp_dat, input lane_t exp_oe, input logic exp_end,
                             input string what);
        repeat ($urandom % 3) @(posedge sd_clk);
        @(posedge sd_clk);
        tx_en <= 1'b1;
        @(negedge sd_clk);
        expect_value(tx_byte_end, exp_end, {what, " byte end"});
        @(posedge sd_clk);
        tx_en <= 1'b0;
        @(negedge sd_clk);
        expect_value(dat_out, exp_dat, what);
        expect_value(dat_oe, exp_oe, {what, " oe"});
    endtask

    task automatic dma_give(input data_byte_t b);
        repeat ($urandom % 4) @(posedge sd_clk);
        @(posedge sd_clk);
        tx_rdy  <= 1'b1;
        tx_byte <= b;
        @(posedge sd_clk);
        tx_rdy  <= 1'b0;
    endtask

    task automatic write_block(input int nbytes);
        crc_bank_t  ref_crc;
        data_byte_t b;
        lane_t      act;
        lane_t      bits;
        int         nbits;
        ref_crc = '0;
        act = wide ? 4'b1111 : 4'b0001;
        nbits = wide ? 2 : 8;
        b = data_byte_t'($urandom);
        dma_give(b);
        for (int p = 0; p < `SDIO_NWR_BITS; p++)
            tx_strobe(4'b1111, act, 1'b0, "preamble");
        tx_strobe(~act, act, 1'b0, "start bit");
        for (int i = 0; i < nbytes; i++) begin
            for (int k = 0; k < nbits; k++) begin
                bits = wide ? ((k == 0) ? b[7:4] : b[3:0]) : {3'b111, b[7-k]};
                for (int l = 0; l < 4; l++)
                    if (wide || l == 0) ref_crc[l] = crc_next(ref_crc[l], bits[l]);
                tx_strobe(bits, act, k == nbits - 1, "write data");
            end
            if (i < nbytes - 1) begin
                b = data_byte_t'($urandom);
                dma_give(b);
            end
        end
        for (int k = 15; k >= 0; k--) begin
            for (int l = 0; l < 4; l++)
                bits[l] = (wide || l == 0) ? ref_crc[l][k] : 1'b1;
            tx_strobe(bits, act, 1'b0, "write crc");
        end
        tx_strobe(4'b1111, act, 1'b0, "end bit");
        tx_strobe(4'b1111, 4'b0000, 1'b0, "release");
    endtask

    initial begin
        int gap_before;
        int done_before;
        void'($urandom(32'hc6bf0a86));
        rstn       = 1'b0;
        dat_start  = 1'b0;
        dir        = 1'b0;
        wide       = 1'b0;
        bsize      = '0;
        bcount     = '0;
        gap_stop   = 1'b0;
        rx_en      = 1'b0;
        tx_en      = 1'b0;
        rx_rdy     = 1'b0;
        tx_rdy     = 1'b0;
        tx_byte    = '0;
        dat_in     = '1;
        err_cnt    = 0;
        chk_cnt    = 0;
        gap_cnt    = 0;
        done_cnt   = 0;
        crc_ev_cnt = 0;
        end_ev_cnt = 0;
        repeat (3) @(posedge sd_clk);
        rstn <= 1'b1;

        start_transfer(1'b1, 1'b0, 4, 1);
        read_block(4, 1'b0, 1'b0);
        start_transfer(1'b1, 1'b1, 6, 1);
        read_block(6, 1'b0, 1'b0);
        start_transfer(1'b1, 1'b0, 3, 1);
        read_block(3, 1'b1, 1'b0);
        start_transfer(1'b1, 1'b1, 3, 1);
        read_block(3, 1'b0, 1'b1);

        start_transfer(1'b0, 1'b0, 4, 1);
        write_block(4);
        start_transfer(1'b0, 1'b1, 5, 1);
        write_block(5);

        // three blocks with each gap held by the stop level
        @(posedge sd_clk);
        gap_stop <= 1'b1;
        @(posedge sd_clk);
        gap_before  = gap_cnt;
        done_before = done_cnt;
        start_transfer(1'b0, 1'b1, 3, 3);
        for (int blk = 0; blk < 3; blk++) begin
            if (blk > 0) begin
                repeat (6) tx_strobe(4'b1111, 4'b0000, 1'b0, "gap hold");
                @(posedge sd_clk);
                gap_stop <= 1'b0;
                @(posedge sd_clk);
                @(posedge sd_clk);
                gap_stop <= 1'b1;
                repeat (2) @(posedge sd_clk);
            end
            write_block(3);
        end
        @(posedge sd_clk);
        gap_stop <= 1'b0;
        repeat (4) @(posedge sd_clk);
        expect_value(gap_cnt - gap_before, 2, "block gap events");
        expect_value(done_cnt - done_before, 1, "done pulses");

        expect_value(crc_ev_cnt, 1, "crc error events");
        expect_value(end_ev_cnt, 1, "end bit error events");
        expect_value(done_cnt, 7, "total done pulses");
        expect_value(rx_exp.size(), 0, "read bytes left over");

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sd_clk);
        $display("timeout: transfers not finished after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
design/sdio_line_pkg.sv
design/sdio_seq_pkg.sv
design/sdio_dat_ifs.sv
design/crc16_bank.sv
design/dat_rx_engine.sv
design/dat_tx_engine.sv
design/dat_ctrl.sv
design/sdio_dat_top.sv
bench/sdio_dat_properties.sv
bench/tb_sdio_dat.sv

//--- run_sim.sh
#!/bin/sh
# build and run the SDIO DAT testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_sdio_dat -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
